// File: design/blit_pkg.sv
// Blitter address unit shared definitions
// Default widths and the vector types for pixel positions, fractions,
// linear addresses, window width and the phrase-mask selector

package blit_pkg;

	// Integer pixel coordinate width
	parameter int POS_W = 16;

	// Fraction part width
	parameter int FRAC_W = 16;

	// Linear pixel address width
	parameter int ADDR_W = 24;

	// Window width value, in pixels
	parameter int WIDTH_W = 12;

	// One integer coordinate or integer increment
	typedef logic [POS_W-1:0] pos_t;

	// One fraction or fraction increment
	typedef logic [FRAC_W-1:0] frac_t;

	// Memory address
	typedef logic [ADDR_W-1:0] addr_t;

	// Window width in pixels
	typedef logic [WIDTH_W-1:0] width_t;

	// Phrase mask select, 1 to 6 clears that many low X bits
	typedef logic [2:0] modx_t;

endpackage

// File: design/frac_accum.sv
// Fraction accumulators for the blitter address unit
// Keeps the X and Y fraction parts and registers the carry or borrow
// of each step, which feeds the integer adder on the next step

`timescale 1ns/1ps

module frac_accum #(
	parameter int FRAC_W = blit_pkg::FRAC_W
) (
	input  logic            sys_clk,
	input  logic            arst_n,
	input  logic            load,
	input  logic            step,
	input  logic            frac_en,
	input  logic            sub_x,
	input  logic            sub_y,
	input  blit_pkg::frac_t frac_start_x,
	input  blit_pkg::frac_t frac_start_y,
	input  blit_pkg::frac_t frac_inc_x,
	input  blit_pkg::frac_t frac_inc_y,
	output logic            carry_x,
	output logic            carry_y
);

	// Current fractions
	logic [FRAC_W-1:0] frac_x;
	logic [FRAC_W-1:0] frac_y;

	// One-bit-wider step results, top bit is carry or borrow
	logic [FRAC_W:0] next_x;
	logic [FRAC_W:0] next_y;

	// Add or subtract one axis, zero-extended so bit FRAC_W
	// comes out as overflow on add and borrow on subtract
	function automatic logic [FRAC_W:0] frac_step(
		input logic [FRAC_W-1:0] frac,
		input logic [FRAC_W-1:0] inc,
		input logic              sub
	);
		logic [FRAC_W:0] res;
		if (sub) begin
			res = {1'b0, frac} - {1'b0, inc};
		end else begin
			res = {1'b0, frac} + {1'b0, inc};
		end
		return res;
	endfunction

	assign next_x = frac_step(frac_x, frac_inc_x, sub_x);
	assign next_y = frac_step(frac_y, frac_inc_y, sub_y);

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			frac_x  <= '0;
			frac_y  <= '0;
			carry_x <= 1'b0;
			carry_y <= 1'b0;
		end else if (load) begin
			// Load wins over step and drops any pending carry
			frac_x  <= frac_start_x;
			frac_y  <= frac_start_y;
			carry_x <= 1'b0;
			carry_y <= 1'b0;
		end else if (step) begin
			frac_x  <= next_x[FRAC_W-1:0];
			frac_y  <= next_y[FRAC_W-1:0];
			// Carry only passes on when fractions are enabled
			carry_x <= next_x[FRAC_W] & frac_en;
			carry_y <= next_y[FRAC_W] & frac_en;
		end
	end

endmodule

// File: design/int_pos_adder.sv
// Integer position adder for the blitter address unit
// Adds or subtracts the X and Y increments with the registered fraction
// carry as carry-in, then aligns X to a phrase by masking its low bits

`timescale 1ns/1ps

module int_pos_adder #(
	parameter int POS_W = blit_pkg::POS_W
) (
	input  logic            sys_clk,
	input  logic            arst_n,
	input  logic            load,
	input  logic            step,
	input  logic            sub_x,
	input  logic            sub_y,
	input  logic            carry_x,
	input  logic            carry_y,
	input  blit_pkg::modx_t modx,
	input  blit_pkg::pos_t  start_x,
	input  blit_pkg::pos_t  start_y,
	input  blit_pkg::pos_t  inc_x,
	input  blit_pkg::pos_t  inc_y,
	output blit_pkg::pos_t  pos_x,
	output blit_pkg::pos_t  pos_y,
	output logic            pos_strobe
);

	// Raw step results before masking
	logic [POS_W-1:0] sum_x;
	logic [POS_W-1:0] sum_y;

	// X after phrase alignment
	logic [POS_W-1:0] masked_x;

	// One-hot of modx, bit 7 falls off so modx 7 gives no mask
	logic [6:0] mask_hot;

	// Thermometer of low X bits to clear
	logic [5:0] clr_bits;

	// One axis of position plus or minus increment
	// Subtract inverts the increment and the carry-in, so
	// pos + ~inc + ~carry equals pos - inc - carry
	// The carry-in is split across both operand LSBs, which
	// turns the three-input add into a single two-input sum
	function automatic logic [POS_W-1:0] pos_step(
		input logic [POS_W-1:0] pos,
		input logic [POS_W-1:0] inc,
		input logic             sub,
		input logic             carry
	);
		logic             cin;
		logic [POS_W-1:0] inc_eff;
		logic [POS_W:0]   wide;
		cin     = carry ^ sub;
		inc_eff = sub ? ~inc : inc;
		wide    = {pos, cin} + {inc_eff, cin};
		return wide[POS_W:1];
	endfunction

	assign sum_x = pos_step(pos_x, inc_x, sub_x, carry_x);
	assign sum_y = pos_step(pos_y, inc_y, sub_y, carry_y);

	// Decode modx into a mask of the lowest modx bits
	always_comb begin
		mask_hot    = 7'd1 << modx;
		clr_bits[5] = mask_hot[6];
		for (int i = 4; i >= 0; i--) begin
			clr_bits[i] = mask_hot[i+1] | clr_bits[i+1];
		end
	end

	// Only X is aligned, upper bits pass untouched
	assign masked_x = sum_x & {{(POS_W-6){1'b1}}, ~clr_bits};

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			pos_x      <= '0;
			pos_y      <= '0;
			pos_strobe <= 1'b0;
		end else begin
			// Marks a fresh position for the address stage
			pos_strobe <= load | step;
			if (load) begin
				pos_x <= start_x;
				pos_y <= start_y;
			end else if (step) begin
				pos_x <= masked_x;
				pos_y <= sum_y;
			end
		end
	end

endmodule

// File: design/addr_compose.sv
// Linear address composer for the blitter address unit
// Turns an X,Y pixel position into base + ((Y * width + X) << pix_shift)
// and registers it, with a one-cycle strobe, after each position update

`timescale 1ns/1ps

module addr_compose #(
	parameter int POS_W   = blit_pkg::POS_W,
	parameter int ADDR_W  = blit_pkg::ADDR_W,
	parameter int WIDTH_W = blit_pkg::WIDTH_W
) (
	input  logic             sys_clk,
	input  logic             arst_n,
	input  logic             pos_strobe,
	input  blit_pkg::pos_t   pos_x,
	input  blit_pkg::pos_t   pos_y,
	input  blit_pkg::addr_t  base,
	input  blit_pkg::width_t width,
	input  logic [2:0]       pix_shift,
	output blit_pkg::addr_t  addr,
	output logic             addr_strobe
);

	// Start of the row, full product width
	logic [POS_W+WIDTH_W-1:0] row_off;

	// Pixel index inside the window, one extra bit for the add
	logic [POS_W+WIDTH_W:0] pix_idx;

	// Pixel index scaled to bytes, wraps at ADDR_W
	logic [ADDR_W-1:0] byte_off;

	// Address ready to be captured
	logic [ADDR_W-1:0] next_addr;

	assign row_off = pos_y * width;
	assign pix_idx = row_off + pos_x;

	// Truncate before shifting, the result is modulo 2^ADDR_W anyway
	assign byte_off = ADDR_W'(pix_idx) << pix_shift;

	assign next_addr = base + byte_off;

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			addr        <= '0;
			addr_strobe <= 1'b0;
		end else begin
			addr_strobe <= pos_strobe;
			// Held between updates
			if (pos_strobe) begin
				addr <= next_addr;
			end
		end
	end

endmodule

// File: design/blit_addr_unit.sv
// Blitter address unit top level
// Fraction accumulator, integer position adder and address composer
// for walking a 2-D pixel window one step at a time

`timescale 1ns/1ps

module blit_addr_unit #(
	parameter int POS_W   = blit_pkg::POS_W,
	parameter int FRAC_W  = blit_pkg::FRAC_W,
	parameter int ADDR_W  = blit_pkg::ADDR_W,
	parameter int WIDTH_W = blit_pkg::WIDTH_W
) (
	input  logic             sys_clk,
	input  logic             arst_n,
	// Control pulses
	input  logic             load,
	input  logic             step,
	// Start position
	input  blit_pkg::pos_t   start_x,
	input  blit_pkg::pos_t   start_y,
	input  blit_pkg::frac_t  frac_start_x,
	input  blit_pkg::frac_t  frac_start_y,
	// Per-step increments
	input  blit_pkg::pos_t   inc_x,
	input  blit_pkg::pos_t   inc_y,
	input  blit_pkg::frac_t  frac_inc_x,
	input  blit_pkg::frac_t  frac_inc_y,
	// Step mode
	input  logic             sub_x,
	input  logic             sub_y,
	input  logic             frac_en,
	input  blit_pkg::modx_t  modx,
	// Window layout
	input  blit_pkg::addr_t  base,
	input  blit_pkg::width_t width,
	input  logic [2:0]       pix_shift,
	// Results
	output blit_pkg::pos_t   pos_x,
	output blit_pkg::pos_t   pos_y,
	output logic             pos_strobe,
	output blit_pkg::addr_t  addr,
	output logic             addr_strobe
);

	// Registered fraction carries into the integer adder
	logic carry_x;
	logic carry_y;

	frac_accum #(
		.FRAC_W (FRAC_W)
	) u_frac_accum (
		.sys_clk      (sys_clk),
		.arst_n       (arst_n),
		.load         (load),
		.step         (step),
		.frac_en      (frac_en),
		.sub_x        (sub_x),
		.sub_y        (sub_y),
		.frac_start_x (frac_start_x),
		.frac_start_y (frac_start_y),
		.frac_inc_x   (frac_inc_x),
		.frac_inc_y   (frac_inc_y),
		.carry_x      (carry_x),
		.carry_y      (carry_y)
	);

	int_pos_adder #(
		.POS_W (POS_W)
	) u_int_pos_adder (
		.sys_clk    (sys_clk),
		.arst_n     (arst_n),
		.load       (load),
		.step       (step),
		.sub_x      (sub_x),
		.sub_y      (sub_y),
		.carry_x    (carry_x),
		.carry_y    (carry_y),
		.modx       (modx),
		.start_x    (start_x),
		.start_y    (start_y),
		.inc_x      (inc_x),
		.inc_y      (inc_y),
		.pos_x      (pos_x),
		.pos_y      (pos_y),
		.pos_strobe (pos_strobe)
	);

	// Position outputs also feed the address stage
	addr_compose #(
		.POS_W   (POS_W),
		.ADDR_W  (ADDR_W),
		.WIDTH_W (WIDTH_W)
	) u_addr_compose (
		.sys_clk     (sys_clk),
		.arst_n      (arst_n),
		.pos_strobe  (pos_strobe),
		.pos_x       (pos_x),
		.pos_y       (pos_y),
		.base        (base),
		.width       (width),
		.pix_shift   (pix_shift),
		.addr        (addr),
		.addr_strobe (addr_strobe)
	);

endmodule

// File: tb/blit_addr_tb.sv
// Testbench for the blitter address unit
// Reads commands and expected results from the stimulus file, drives the DUT
// and scores every position and address update against its due cycle

`timescale 1ns/1ps

module blit_addr_tb;

	// DUT inputs
	logic             sys_clk;
	logic             arst_n;
	logic             load;
	logic             step;
	blit_pkg::pos_t   start_x;
	blit_pkg::pos_t   start_y;
	blit_pkg::frac_t  frac_start_x;
	blit_pkg::frac_t  frac_start_y;
	blit_pkg::pos_t   inc_x;
	blit_pkg::pos_t   inc_y;
	blit_pkg::frac_t  frac_inc_x;
	blit_pkg::frac_t  frac_inc_y;
	logic             sub_x;
	logic             sub_y;
	logic             frac_en;
	blit_pkg::modx_t  modx;
	blit_pkg::addr_t  base;
	blit_pkg::width_t width;
	logic [2:0]       pix_shift;

	// DUT outputs
	blit_pkg::pos_t   pos_x;
	blit_pkg::pos_t   pos_y;
	logic             pos_strobe;
	blit_pkg::addr_t  addr;
	logic             addr_strobe;

	// Fields of one stimulus line
	logic [127:0]     f_name;
	logic [7:0]       f_cmd;
	logic [3:0]       f_gap;
	logic [15:0]      f_opx;
	logic [15:0]      f_opy;
	logic [15:0]      f_fopx;
	logic [15:0]      f_fopy;
	logic             f_subx;
	logic             f_suby;
	logic             f_fen;
	logic [2:0]       f_modx;
	logic [23:0]      f_base;
	logic [11:0]      f_width;
	logic [2:0]       f_shift;
	logic [15:0]      f_exp_x;
	logic [15:0]      f_exp_y;
	logic [23:0]      f_exp_addr;

	// Updates in flight with the oldest first
	logic [127:0]     pos_name_q[$];
	int               pos_due_q[$];
	logic [15:0]      exp_x_q[$];
	logic [15:0]      exp_y_q[$];
	logic [127:0]     addr_name_q[$];
	int               addr_due_q[$];
	logic [23:0]      exp_addr_q[$];

	// Cycle count bumped on every rising edge
	int               cyc;
	integer           seed;

	blit_addr_unit DUT (
		.sys_clk      (sys_clk),
		.arst_n       (arst_n),
		.load         (load),
		.step         (step),
		.start_x      (start_x),
		.start_y      (start_y),
		.frac_start_x (frac_start_x),
		.frac_start_y (frac_start_y),
		.inc_x        (inc_x),
		.inc_y        (inc_y),
		.frac_inc_x   (frac_inc_x),
		.frac_inc_y   (frac_inc_y),
		.sub_x        (sub_x),
		.sub_y        (sub_y),
		.frac_en      (frac_en),
		.modx         (modx),
		.base         (base),
		.width        (width),
		.pix_shift    (pix_shift),
		.pos_x        (pos_x),
		.pos_y        (pos_y),
		.pos_strobe   (pos_strobe),
		.addr         (addr),
		.addr_strobe  (addr_strobe)
	);

	// 100 ns clock
	always #50 sys_clk = ~sys_clk;

	always @(posedge sys_clk) begin
		cyc <= cyc + 1;
	end

	// Print the reason and stop the run
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	// Lines starting with # or empty ones carry no command
	function automatic bit is_comment_line(input string line);
		if (line.len() < 2) begin
			return 1'b1;
		end
		return (line[0] == "#");
	endfunction

	task automatic drive_idle;
		load = 1'b0;
		step = 1'b0;
	endtask

	// Operands are start values on a load and increments on a step
	// The operand set not in use carries the inverted value
	task automatic apply_line;
		if (f_cmd != "L" && f_cmd != "S" && f_cmd != "B") begin
			abort_run($sformatf("unknown command in stimulus line %0s", f_name));
		end else begin
			load         = (f_cmd == "L") || (f_cmd == "B");
			step         = (f_cmd == "S") || (f_cmd == "B");
			if (load) begin
				start_x      = f_opx;
				start_y      = f_opy;
				frac_start_x = f_fopx;
				frac_start_y = f_fopy;
				inc_x        = ~f_opx;
				inc_y        = ~f_opy;
				frac_inc_x   = ~f_fopx;
				frac_inc_y   = ~f_fopy;
			end else begin
				start_x      = ~f_opx;
				start_y      = ~f_opy;
				frac_start_x = ~f_fopx;
				frac_start_y = ~f_fopy;
				inc_x        = f_opx;
				inc_y        = f_opy;
				frac_inc_x   = f_fopx;
				frac_inc_y   = f_fopy;
			end
			sub_x        = f_subx;
			sub_y        = f_suby;
			frac_en      = f_fen;
			modx         = f_modx;
			base         = f_base;
			width        = f_width;
			pix_shift    = f_shift;
			// Position due one cycle later and address two cycles later
			pos_name_q.push_back(f_name);
			pos_due_q.push_back(cyc + 1);
			exp_x_q.push_back(f_exp_x);
			exp_y_q.push_back(f_exp_y);
			addr_name_q.push_back(f_name);
			addr_due_q.push_back(cyc + 2);
			exp_addr_q.push_back(f_exp_addr);
		end
	endtask

	task automatic score_position;
		if (pos_strobe && pos_name_q.size() == 0) begin
			abort_run("pos_strobe pulsed with no load or step pending");
		end else if (pos_strobe) begin
			assert (pos_due_q[0] == cyc) else
				abort_run($sformatf("pos_strobe for %0s came in cycle %0d instead of %0d",
					pos_name_q[0], cyc, pos_due_q[0]));
			assert (pos_x === exp_x_q[0]) else
				abort_run($sformatf("Mismatch in %0s: pos_x expected %h, actual %h",
					pos_name_q[0], exp_x_q[0], pos_x));
			assert (pos_y === exp_y_q[0]) else
				abort_run($sformatf("Mismatch in %0s: pos_y expected %h, actual %h",
					pos_name_q[0], exp_y_q[0], pos_y));
			pos_name_q.delete(0);
			pos_due_q.delete(0);
			exp_x_q.delete(0);
			exp_y_q.delete(0);
		end else if (pos_name_q.size() != 0 && pos_due_q[0] < cyc) begin
			abort_run($sformatf("pos_strobe never came for %0s", pos_name_q[0]));
		end
	endtask

	task automatic score_address;
		if (addr_strobe && addr_name_q.size() == 0) begin
			abort_run("addr_strobe pulsed with no position update pending");
		end else if (addr_strobe) begin
			assert (addr_due_q[0] == cyc) else
				abort_run($sformatf("addr_strobe for %0s came in cycle %0d instead of %0d",
					addr_name_q[0], cyc, addr_due_q[0]));
			assert (addr === exp_addr_q[0]) else
				abort_run($sformatf("Mismatch in %0s: addr expected %h, actual %h",
					addr_name_q[0], exp_addr_q[0], addr));
			addr_name_q.delete(0);
			addr_due_q.delete(0);
			exp_addr_q.delete(0);
		end else if (addr_name_q.size() != 0 && addr_due_q[0] < cyc) begin
			abort_run($sformatf("addr_strobe never came for %0s", addr_name_q[0]));
		end
	endtask

	// Outputs settle well before the falling edge
	always @(negedge sys_clk) begin
		if (arst_n) begin
			score_position;
			score_address;
		end
	end

	// Nothing moves until the first command
	task automatic watch_reset_outputs;
		for (int i = 0; i < 4; i++) begin
			@(negedge sys_clk);
			assert (!pos_strobe && !addr_strobe) else
				abort_run("a strobe went high after reset without any command");
			assert (addr === 24'h0) else
				abort_run($sformatf("Mismatch in reset: addr expected %h, actual %h",
					24'h0, addr));
		end
	endtask

	// Let the last addresses come out within a bounded wait
	task automatic drain_pending;
		int n;
		n = 0;
		while (addr_name_q.size() != 0 && n < 10) begin
			@(posedge sys_clk);
			n++;
		end
		if (addr_name_q.size() != 0) begin
			abort_run($sformatf("addr_strobe never came for %0s", addr_name_q[0]));
		end
	endtask

	initial begin
		int    fd;
		int    got;
		int    idle;
		string line;
		seed         = 32'hc62c;
		cyc          = 0;
		sys_clk      = 1'b0;
		arst_n       = 1'b0;
		start_x      = '0;
		start_y      = '0;
		frac_start_x = '0;
		frac_start_y = '0;
		inc_x        = '0;
		inc_y        = '0;
		frac_inc_x   = '0;
		frac_inc_y   = '0;
		sub_x        = 1'b0;
		sub_y        = 1'b0;
		frac_en      = 1'b0;
		modx         = '0;
		base         = '0;
		width        = '0;
		pix_shift    = '0;
		drive_idle;
		fd = $fopen("tb/blit_addr_stimulus.txt", "r");
		if (fd == 0) begin
			abort_run("cannot open tb/blit_addr_stimulus.txt");
		end
		// Reset for 3 cycles
		repeat (3) @(posedge sys_clk);
		#5 arst_n = 1'b1;
		watch_reset_outputs;
		while (!$feof(fd)) begin
			line = "";
			got  = $fgets(line, fd);
			if (got > 0 && !is_comment_line(line)) begin
				got = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					f_name, f_cmd, f_gap, f_opx, f_opy, f_fopx, f_fopy, f_subx, f_suby,
					f_fen, f_modx, f_base, f_width, f_shift, f_exp_x, f_exp_y, f_exp_addr);
				if (got != 17) begin
					abort_run($sformatf("stimulus line has %0d fields instead of 17", got));
				end
				@(posedge sys_clk);
				#5;
				apply_line;
				// Gap f picks 0 to 3 idle cycles
				idle = (f_gap == 4'hf) ? ($unsigned($random(seed)) % 4) : int'(f_gap);
				repeat (idle) begin
					@(posedge sys_clk);
					#5;
					drive_idle;
				end
			end
		end
		$fclose(fd);
		@(posedge sys_clk);
		#5;
		drive_idle;
		drain_pending;
		if (pos_name_q.size() != 0) begin
			abort_run($sformatf("pos_strobe never came for %0s", pos_name_q[0]));
		end else begin
			$display("Everything OK");
			$finish;
		end
	end

endmodule

// File: tb/blit_addr_stimulus.txt
# name cmd gap opx opy fopx fopy sbx sby fen modx base width shift exp_x exp_y exp_addr
# cmd L load, S step, B both; op is start on load, increment on step; gap f is random
#
# Load sets position, address is base + ((y * width + x) << shift)
t1_load    L 1 0010 0020 0000 0000 0 0 0 0 001000 040 1 0010 0020 002020
#
# Add steps, a fraction overflow adds one on the following step
t2_load    L 1 0100 0010 c000 0000 0 0 1 0 010000 100 0 0100 0010 011100
t2_add_1   S 1 0003 0002 8000 4000 0 0 1 0 010000 100 0 0103 0012 011303
t2_add_2   S f 0003 0002 8000 4000 0 0 1 0 010000 100 0 0107 0014 011507
t2_add_3   S 2 0003 0002 8000 4000 0 0 1 0 010000 100 0 010a 0016 01170a
t2_add_4   S f 0003 0002 8000 4000 0 0 1 0 010000 100 0 010e 0018 01190e
t2_add_5   S 2 0003 0002 8000 4000 0 0 1 0 010000 100 0 0111 001b 011c11
#
# Subtract steps, a borrow takes one more on the following step
# and the position wraps below zero
t3_load    L 1 0005 0003 1000 0000 1 1 1 0 020000 050 2 0005 0003 0203d4
t3_sub_1   S 1 0002 0001 2000 8000 1 1 1 0 020000 050 2 0003 0002 02028c
t3_sub_2   S 1 0002 0001 2000 8000 1 1 1 0 020000 050 2 0000 0000 020000
t3_sub_3   S f 0002 0001 2000 8000 1 1 1 0 020000 050 2 fffe ffff 45feb8
t3_sub_4   S 2 0002 0001 2000 8000 1 1 1 0 020000 050 2 fffc fffd 45fc30
#
# Phrase masking for every modx, Y is never masked
t4_load    L 1 00ff 0047 0000 0000 0 0 0 0 000000 010 0 00ff 0047 00056f
t4_modx6   S 0 003f 0003 0000 0000 0 0 0 6 000000 010 0 0100 004a 0005a0
t4_modx5   S 0 003f 0003 0000 0000 0 0 0 5 000000 010 0 0120 004d 0005f0
t4_modx4   S 0 003f 0003 0000 0000 0 0 0 4 000000 010 0 0150 0050 000650
t4_modx3   S 0 003f 0003 0000 0000 0 0 0 3 000000 010 0 0188 0053 0006b8
t4_modx2   S 0 003f 0003 0000 0000 0 0 0 2 000000 010 0 01c4 0056 000724
t4_modx1   S 0 003f 0003 0000 0000 0 0 0 1 000000 010 0 0202 0059 000792
t4_modx7   S 0 003f 0003 0000 0000 0 0 0 7 000000 010 0 0241 005c 000801
t4_modx0   S 2 0005 0003 0000 0000 0 0 0 0 000000 010 0 0246 005f 000836
#
# Back-to-back steps with the fraction carry switched off
t5_load    L 1 0200 0100 f000 f000 0 0 0 0 100000 200 3 0200 0100 201000
t5_b2b_1   S 0 0001 0001 2000 2000 0 0 0 0 100000 200 3 0201 0101 202008
t5_b2b_2   S 0 0001 0001 2000 2000 0 0 0 0 100000 200 3 0202 0102 203010
t5_b2b_3   S 0 0001 0001 2000 2000 0 0 0 0 100000 200 3 0203 0103 204018
t5_b2b_4   S 1 0001 0001 2000 2000 0 0 0 0 100000 200 3 0204 0104 205020
#
# Load with a step in the same cycle wins and drops the pending carries
t6_carry   S 1 0001 0001 a000 a000 0 0 1 0 100000 200 3 0205 0105 206028
t6_ldstep  B 1 0300 0080 0000 0000 0 0 1 0 100000 200 3 0300 0080 181800
t6_after   S 2 0001 0001 0000 0000 0 0 1 0 100000 200 3 0301 0081 182808

// File: list.f
design/blit_pkg.sv
design/frac_accum.sv
design/int_pos_adder.sv
design/addr_compose.sv
design/blit_addr_unit.sv
tb/blit_addr_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the blitter address unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -rf obj_dir "$log"

verilator --binary --timing --assert -Wno-fatal \
	--top-module blit_addr_tb \
	-f list.f \
	-o blit_addr_sim
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "Verilator build failed with status $build_status"
	exit 1
fi

if [ ! -x obj_dir/blit_addr_sim ]; then
	echo "Simulation executable is missing"
	exit 1
fi

./obj_dir/blit_addr_sim 2>&1 | tee "$log"
run_status=${PIPESTATUS[0]}

if [ ! -s "$log" ]; then
	echo "Simulation log is empty"
	exit 1
fi

if grep -q "Something failed" "$log"; then
	echo "RESULT: FAIL"
	exit 1
fi

if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

echo "RESULT: PASS"
exit 0
